// ==== logic/rename_config.svh ====
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// sizing of the rename stage

// architectural registers visible to software
`define NUM_GEN_REG 32

// physical registers behind the map table
`define NUM_PHYS_REG 48

// in-order retire buffer entries
`define RB_DEPTH 32

// tags not mapped at reset all start on the free list
`define FL_DEPTH (`NUM_PHYS_REG - `NUM_GEN_REG)

`endif

// ==== logic/rename_pkg.sv ====
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

	// architectural register number
	typedef logic [$clog2(`NUM_GEN_REG)-1:0] arch_reg_t;

	// physical register tag
	typedef logic [$clog2(`NUM_PHYS_REG)-1:0] phys_reg_t;

	// free list occupancy, 0 through FL_DEPTH inclusive
	typedef logic [$clog2(`FL_DEPTH+1)-1:0] fl_count_t;

	// slot number in the retire buffer
	typedef logic [$clog2(`RB_DEPTH)-1:0] rb_idx_t;

	// dispatch request, the strobe travels separately
	typedef struct packed {
		arch_reg_t dest;
	} dispatch_t;

	// rename result, one cycle after accept
	typedef struct packed {
		logic      valid;
		arch_reg_t dest;
		phys_reg_t t;
		phys_reg_t t_old;
		rb_idx_t   rb_idx;
	} rename_rsp_t;

	// one retire buffer slot
	typedef struct packed {
		arch_reg_t dest;
		phys_reg_t t;
		phys_reg_t t_old;
	} rb_entry_t;

	// retire report, one cycle after the retire strobe
	typedef struct packed {
		logic      valid;
		arch_reg_t dest;
		phys_reg_t t;
		phys_reg_t t_old;
	} retire_rec_t;

endpackage

`default_nettype wire

// ==== logic/free_list.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module free_list import rename_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	// tag coming back from retire
	input  logic      push,
	input  phys_reg_t push_tag,
	// tag handed to dispatch
	input  logic      pop,
	output phys_reg_t head_tag,
	output logic      empty,
	output fl_count_t count
);

	localparam int DEPTH = `FL_DEPTH;

	typedef logic [$clog2(DEPTH)-1:0] ptr_t;

	// ring storage for free tags
	phys_reg_t ring [DEPTH];

	// oldest free tag
	ptr_t head;
	// next slot to fill
	ptr_t tail;

	ptr_t head_next;
	ptr_t tail_next;

	// wrap explicitly so a depth that is not a power of two still works
	assign head_next = (head == ptr_t'(DEPTH - 1)) ? '0 : head + 1'b1;
	assign tail_next = (tail == ptr_t'(DEPTH - 1)) ? '0 : tail + 1'b1;

	assign head_tag = ring[head];
	assign empty    = (count == '0);

	// storage, loaded at reset with every tag the map table does not hold
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				ring[i] <= phys_reg_t'(`NUM_GEN_REG + i);
			end
		end else if (push) begin
			ring[tail] <= push_tag;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			// ring starts full so tail has wrapped back to slot 0
			tail  <= '0;
			count <= fl_count_t'(DEPTH);
		end else begin
			if (pop) begin
				head <= head_next;
			end
			if (push) begin
				tail <= tail_next;
			end
			// push and pop together leave the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module map_table import rename_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	// read port, gives T_old for the dispatching dest
	input  arch_reg_t lookup,
	output phys_reg_t lookup_tag,
	// write port, points dest at its new tag
	input  logic      write,
	input  arch_reg_t write_dest,
	input  phys_reg_t write_tag
);

	localparam int NUM_REGS = `NUM_GEN_REG;

	// current physical tag per architectural register
	phys_reg_t map [NUM_REGS];

	// combinational read sees the old mapping
	// a write in the same cycle only lands at the edge
	assign lookup_tag = map[lookup];

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity map, r_i lives in p_i
			for (int i = 0; i < NUM_REGS; i++) begin
				map[i] <= phys_reg_t'(i);
			end
		end else if (write) begin
			map[write_dest] <= write_tag;
		end
	end

endmodule

`default_nettype wire

// ==== logic/retire_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module retire_buffer import rename_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	// new entry from dispatch
	input  logic        push,
	input  rb_entry_t   push_entry,
	// slot the next push will land in
	output rb_idx_t     push_idx,
	output logic        full,
	// retire strobe, ignored while empty
	input  logic        retire,
	// T_old going back to the free list
	output logic        rel_valid,
	output phys_reg_t   rel_tag,
	// registered report of the retired entry
	output retire_rec_t retired
);

	localparam int DEPTH = `RB_DEPTH;

	typedef logic [$clog2(DEPTH+1)-1:0] occ_t;

	// entries in program order, head is the oldest
	rb_entry_t entries [DEPTH];

	rb_idx_t head;
	rb_idx_t tail;
	occ_t    occ;

	rb_idx_t   head_next;
	rb_idx_t   tail_next;
	logic      pop;
	rb_entry_t oldest;

	assign head_next = (head == rb_idx_t'(DEPTH - 1)) ? '0 : head + 1'b1;
	assign tail_next = (tail == rb_idx_t'(DEPTH - 1)) ? '0 : tail + 1'b1;

	assign oldest = entries[head];

	// retire only when there is something to retire
	assign pop = retire && (occ != '0);

	assign full      = (occ == occ_t'(DEPTH));
	assign push_idx  = tail;
	assign rel_valid = pop;
	assign rel_tag   = oldest.t_old;

	// entry storage
	always_ff @(posedge clock) begin
		if (push) begin
			entries[tail] <= push_entry;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			occ  <= '0;
		end else begin
			if (push) begin
				tail <= tail_next;
			end
			if (pop) begin
				head <= head_next;
			end
			case ({push, pop})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
		end
	end

	// report the retired entry one cycle after the strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			retired.valid <= 1'b0;
		end else begin
			retired.valid <= pop;
			if (pop) begin
				retired.dest  <= oldest.dest;
				retired.t     <= oldest.t;
				retired.t_old <= oldest.t_old;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/rename_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module rename_core import rename_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        dispatch,
	input  dispatch_t   dispatch_op,
	input  logic        retire,
	output logic        stall,
	output rename_rsp_t rename_rsp,
	output retire_rec_t retired,
	output fl_count_t   free_count
);

	// free list side
	phys_reg_t free_tag;
	logic      fl_empty;

	// map table side
	phys_reg_t old_tag;

	// retire buffer side
	logic      rb_full;
	rb_idx_t   push_idx;
	rb_entry_t rb_push_entry;
	logic      rel_valid;
	phys_reg_t rel_tag;

	logic accept;

	// no free tag or no room to track the instruction
	assign stall  = fl_empty || rb_full;
	// a stalled dispatch is dropped, the source holds it
	assign accept = dispatch && !stall;

	assign rb_push_entry = '{dest: dispatch_op.dest, t: free_tag, t_old: old_tag};

	free_list u_free_list (
		.clock    (clock),
		.reset    (reset),
		.push     (rel_valid),
		.push_tag (rel_tag),
		.pop      (accept),
		.head_tag (free_tag),
		.empty    (fl_empty),
		.count    (free_count)
	);

	map_table u_map_table (
		.clock      (clock),
		.reset      (reset),
		.lookup     (dispatch_op.dest),
		.lookup_tag (old_tag),
		.write      (accept),
		.write_dest (dispatch_op.dest),
		.write_tag  (free_tag)
	);

	retire_buffer u_retire_buffer (
		.clock      (clock),
		.reset      (reset),
		.push       (accept),
		.push_entry (rb_push_entry),
		.push_idx   (push_idx),
		.full       (rb_full),
		.retire     (retire),
		.rel_valid  (rel_valid),
		.rel_tag    (rel_tag),
		.retired    (retired)
	);

	// rename result, values sampled in the accept cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			rename_rsp.valid <= 1'b0;
		end else begin
			rename_rsp.valid <= accept;
			if (accept) begin
				rename_rsp.dest   <= dispatch_op.dest;
				rename_rsp.t      <= free_tag;
				rename_rsp.t_old  <= old_tag;
				rename_rsp.rb_idx <= push_idx;
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/rename_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module rename_core_tb import rename_pkg::*; ();

	// cycle budget, tests need about 1200 cycles
	localparam int TIMEOUT_CYCLES = 3000;
	localparam int RANDOM_CYCLES  = 1000;

	logic        clock;
	logic        reset;
	logic        dispatch;
	dispatch_t   dispatch_op;
	logic        retire;
	logic        stall;
	rename_rsp_t rename_rsp;
	retire_rec_t retired;
	fl_count_t   free_count;

	// reference model state
	phys_reg_t   free_q [$];
	phys_reg_t   map_m [`NUM_GEN_REG];
	rb_entry_t   rb_q [$];
	rb_idx_t     rb_tail_m;

	// expected outputs, updated at each rising edge
	rename_rsp_t exp_rsp;
	retire_rec_t exp_ret;
	logic        exp_stall;
	fl_count_t   exp_count;

	integer seed;
	int     cycle_count;
	int     error_count;
	int     errors_at_start;
	int     tests_passed;
	int     tests_failed;

	rename_core DUT (
		.clock       (clock),
		.reset       (reset),
		.dispatch    (dispatch),
		.dispatch_op (dispatch_op),
		.retire      (retire),
		.stall       (stall),
		.rename_rsp  (rename_rsp),
		.retired     (retired),
		.free_count  (free_count)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// model follows the same accept and retire rules as the stage
	always @(posedge clock) begin : model
		logic      acc;
		logic      ret;
		rb_entry_t oldest;
		if (reset) begin
			free_q.delete();
			rb_q.delete();
			for (int i = 0; i < `FL_DEPTH; i++) begin
				free_q.push_back(phys_reg_t'(`NUM_GEN_REG + i));
			end
			for (int i = 0; i < `NUM_GEN_REG; i++) begin
				map_m[i] = phys_reg_t'(i);
			end
			rb_tail_m     = '0;
			exp_rsp.valid = 1'b0;
			exp_ret.valid = 1'b0;
		end else begin
			// stall is decided on the state before this edge
			acc = dispatch && !(free_q.size() == 0 || rb_q.size() == `RB_DEPTH);
			ret = retire && (rb_q.size() != 0);
			oldest = ret ? rb_q[0] : '0;
			exp_rsp.valid = acc;
			if (acc) begin
				exp_rsp.dest   = dispatch_op.dest;
				exp_rsp.t      = free_q[0];
				exp_rsp.t_old  = map_m[dispatch_op.dest];
				exp_rsp.rb_idx = rb_tail_m;
				void'(free_q.pop_front());
				map_m[dispatch_op.dest] = exp_rsp.t;
				rb_q.push_back('{dest: exp_rsp.dest, t: exp_rsp.t, t_old: exp_rsp.t_old});
				rb_tail_m = (rb_tail_m == rb_idx_t'(`RB_DEPTH - 1)) ? '0 : rb_tail_m + 1'b1;
			end
			exp_ret.valid = ret;
			if (ret) begin
				exp_ret.dest  = oldest.dest;
				exp_ret.t     = oldest.t;
				exp_ret.t_old = oldest.t_old;
				void'(rb_q.pop_front());
				// freed tag queues behind the tags already free
				free_q.push_back(oldest.t_old);
			end
		end
		exp_count = fl_count_t'(free_q.size());
		exp_stall = (free_q.size() == 0) || (rb_q.size() == `RB_DEPTH);
	end

	// outputs only move at rising edges, so compare at falling edges
	assert property (@(negedge clock) disable iff (reset) stall == exp_stall)
	else begin
		$display("mismatch at %0t: stall expected %0b actual %0b", $time, exp_stall, stall);
		error_count++;
	end

	assert property (@(negedge clock) disable iff (reset) free_count == exp_count)
	else begin
		$display("mismatch at %0t: free_count expected %0d actual %0d",
			$time, exp_count, free_count);
		error_count++;
	end

	assert property (@(negedge clock) disable iff (reset) rename_rsp.valid == exp_rsp.valid)
	else begin
		$display("mismatch at %0t: rename_rsp.valid expected %0b actual %0b",
			$time, exp_rsp.valid, rename_rsp.valid);
		error_count++;
	end

	// payload only matters while valid
	assert property (@(negedge clock) disable iff (reset) exp_rsp.valid |-> rename_rsp == exp_rsp)
	else begin
		$display("mismatch at %0t: rename_rsp expected %h actual %h", $time, exp_rsp, rename_rsp);
		error_count++;
	end

	assert property (@(negedge clock) disable iff (reset) retired.valid == exp_ret.valid)
	else begin
		$display("mismatch at %0t: retired.valid expected %0b actual %0b",
			$time, exp_ret.valid, retired.valid);
		error_count++;
	end

	assert property (@(negedge clock) disable iff (reset) exp_ret.valid |-> retired == exp_ret)
	else begin
		$display("mismatch at %0t: retired expected %h actual %h", $time, exp_ret, retired);
		error_count++;
	end

	// hard stop if the sequence never ends
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	// one cycle of inputs, applied on the falling edge
	task automatic drive_cycle(input logic d, input arch_reg_t dest, input logic r);
		@(negedge clock);
		dispatch         = d;
		dispatch_op.dest = dest;
		retire           = r;
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(1'b0, '0, 1'b0);
	endtask

	task automatic start_test();
		errors_at_start = error_count;
	endtask

	// let the last outputs reach the checkers, then score the test
	task automatic finish_test(input string name);
		idle(2);
		if (error_count == errors_at_start) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, error_count - errors_at_start);
		end
	endtask

	initial begin : stimulus
		logic [31:0] r;
		fl_count_t   count_before;
		seed        = 32'h4203;
		cycle_count = 0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		reset       = 1'b1;
		dispatch    = 1'b0;
		dispatch_op = '0;
		retire      = 1'b0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// counts, stall and valids straight out of reset
		start_test();
		idle(2);
		finish_test("reset_state");

		// repeated dests chain t_old through earlier renames
		start_test();
		for (int i = 0; i < 8; i++) begin
			drive_cycle(1'b1, arch_reg_t'(i % 3), 1'b0);
		end
		finish_test("dispatch_rename");

		// two extra strobes land on an empty buffer
		start_test();
		repeat (10) drive_cycle(1'b0, '0, 1'b1);
		// released tags come back after 40..47
		for (int i = 0; i < 10; i++) begin
			drive_cycle(1'b1, arch_reg_t'(i + 4), 1'b0);
		end
		finish_test("retire");

		// six tags left, the rest of the burst is dropped
		start_test();
		for (int i = 0; i < 20; i++) begin
			drive_cycle(1'b1, arch_reg_t'(i), 1'b0);
		end
		idle(1);
		assert (stall === 1'b1)
		else begin
			$display("mismatch at %0t: stall expected 1 actual %0b", $time, stall);
			error_count++;
		end
		drive_cycle(1'b0, '0, 1'b1);
		idle(1);
		assert (stall === 1'b0)
		else begin
			$display("mismatch at %0t: stall expected 0 actual %0b", $time, stall);
			error_count++;
		end
		finish_test("exhaustion");

		// pop and push in the same cycle, count holds
		start_test();
		count_before = free_count;
		for (int i = 0; i < 6; i++) begin
			drive_cycle(1'b1, arch_reg_t'(31 - i), 1'b1);
		end
		idle(1);
		assert (free_count === count_before)
		else begin
			$display("mismatch at %0t: free_count expected %0d actual %0d",
				$time, count_before, free_count);
			error_count++;
		end
		finish_test("dispatch_and_retire");

		// dispatch leans heavier than retire so stall shows up
		start_test();
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			r = $random(seed);
			drive_cycle(r[0] | r[1], r[8:4], r[2]);
		end
		repeat (`RB_DEPTH + 2) drive_cycle(1'b0, '0, 1'b1);
		finish_test("random_mix");

		$display("tests passed %0d failed %0d, check errors %0d",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rename_core.f ====
+incdir+logic
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/retire_buffer.sv
logic/rename_core.sv
dv/rename_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the rename stage testbench with Verilator and run it
# the run counts as passing only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module rename_core_tb \
	-f rename_core.f \
	--Mdir obj_dir \
	-o rename_core_sim \
	&& ./obj_dir/rename_core_sim | tee /dev/stderr | grep -x "TB PASSED" > /dev/null \
	&& echo "simulation run: pass" \
	|| { echo "simulation run: fail"; exit 1; }

exit 0
